// File: files.f
+incdir+source
source/exStagePkg.sv
source/aluCore.sv
source/hiLoUnit.sv
source/branchUnit.sv
source/exMemRegister.sv
source/exStage.sv
verification/exStageTb.sv

// File: source/aluCore.sv
`timescale 1ns/1ps
`include "exStage_macros.svh"

module aluCore (
        input  logic [`EX_DATA_W-1:0]  a,
        input  logic [`EX_DATA_W-1:0]  b,
        input  logic [`EX_DATA_W-1:0]  immediate,
        input  logic [`EX_SHAMT_W-1:0] shamt,
        input  exStagePkg::funcT       func,
        input  logic                   aluSrc,
        output logic [`EX_DATA_W-1:0]  aluResult
);

        logic [`EX_DATA_W-1:0]  opB;
        logic [`EX_SHAMT_W-1:0] varShift;

        assign opB      = aluSrc ? immediate : b;     // Second operand select.
        assign varShift = a[`EX_SHAMT_W-1:0];        // Shift count for sllv and srlv.

        always_comb
        begin
                case (func)
                        exStagePkg::funcAdd,
                        exStagePkg::funcAddu:
                        begin
                                aluResult = a + opB;        // No overflow trap.
                        end
                        exStagePkg::funcSub,
                        exStagePkg::funcSubu:
                        begin
                                aluResult = a - opB;
                        end
                        exStagePkg::funcAnd:
                        begin
                                aluResult = a & opB;
                        end
                        exStagePkg::funcOr:
                        begin
                                aluResult = a | opB;
                        end
                        exStagePkg::funcXor:
                        begin
                                aluResult = a ^ opB;
                        end
                        exStagePkg::funcNor:
                        begin
                                aluResult = ~(a | opB);
                        end
                        exStagePkg::funcSlt:
                        begin
                                aluResult = {{(`EX_DATA_W-1){1'b0}}, $signed(a) < $signed(opB)};
                        end
                        exStagePkg::funcSltu:
                        begin
                                aluResult = {{(`EX_DATA_W-1){1'b0}}, a < opB};
                        end
                        exStagePkg::funcSll:
                        begin
                                aluResult = opB << shamt;
                        end
                        exStagePkg::funcSrl:
                        begin
                                aluResult = opB >> shamt;
                        end
                        exStagePkg::funcSra:
                        begin
                                aluResult = $signed(opB) >>> shamt;  // Keeps the sign bit.
                        end
                        exStagePkg::funcSllv:
                        begin
                                aluResult = opB << varShift;
                        end
                        exStagePkg::funcSrlv:
                        begin
                                aluResult = opB >> varShift;
                        end
                        default:
                        begin
                                aluResult = '0;             // HI/LO codes and unused codes.
                        end
                endcase
        end

endmodule

// File: source/branchUnit.sv
`timescale 1ns/1ps
`include "exStage_macros.svh"

module branchUnit (
        input  logic [`EX_DATA_W-1:0]  a,
        input  logic [`EX_DATA_W-1:0]  b,
        input  logic [`EX_DATA_W-1:0]  immediate,
        input  logic [`EX_DATA_W-1:0]  pcIn,
        input  exStagePkg::branchCondT branchCond,
        output logic                   taken,
        output logic [`EX_DATA_W-1:0]  target
);

        logic [`EX_DATA_W-1:0] diff;
        logic                  zero;

        assign diff = a - b;
        assign zero = (diff == '0);                  // Operands are equal.

        always_comb
        begin
                case (branchCond)
                        exStagePkg::brEq:   taken = zero;
                        exStagePkg::brNe:   taken = !zero;
                        exStagePkg::brJump: taken = 1'b1;
                        default:            taken = 1'b0;
                endcase
        end

        // Branches are PC relative in words, a jump carries its absolute target.
        assign target = (branchCond == exStagePkg::brJump) ? immediate
                                                           : pcIn + (immediate << 2);

endmodule

// File: source/exMemRegister.sv
`timescale 1ns/1ps
`include "exStage_macros.svh"

module exMemRegister (
        input  logic                     Clock,
        input  logic                     arstN,
        input  logic                     inValid,
        input  logic                     taken,
        input  logic                     regWriteIn,
        input  logic                     memReadIn,
        input  logic                     memToRegIn,
        input  logic                     memWriteIn,
        input  logic [`EX_DATA_W-1:0]    result,
        input  logic [`EX_DATA_W-1:0]    storeData,
        input  logic [`EX_DATA_W-1:0]    pcIn,
        input  logic [`EX_DATA_W-1:0]    target,
        input  logic [`EX_REG_ADDR_W-1:0] rAddrIn,
        input  logic [`EX_MEMFUNC_W-1:0] memFuncIn,
        output logic                     outValid,
        output logic [`EX_DATA_W-1:0]    out,
        output logic [`EX_DATA_W-1:0]    rtDataOut,
        output logic [`EX_DATA_W-1:0]    pcOut,
        output logic [`EX_DATA_W-1:0]    branchTarget,
        output logic                     branchTaken,
        output logic [`EX_REG_ADDR_W-1:0] rAddrOut,
        output logic [`EX_MEMFUNC_W-1:0] memFuncOut,
        output logic                     regWriteOut,
        output logic                     memReadOut,
        output logic                     memToRegOut,
        output logic                     memWriteOut
);

        // Control bits load a bubble whenever no item is strobed.
        always_ff @(posedge Clock or negedge arstN)
        begin
                if (!arstN)
                begin
                        outValid    <= 1'b0;
                        branchTaken <= 1'b0;
                        regWriteOut <= 1'b0;
                        memReadOut  <= 1'b0;
                        memToRegOut <= 1'b0;
                        memWriteOut <= 1'b0;
                end
                else
                begin
                        outValid    <= inValid;
                        branchTaken <= inValid & taken;
                        regWriteOut <= inValid & regWriteIn;
                        memReadOut  <= inValid & memReadIn;
                        memToRegOut <= inValid & memToRegIn;
                        memWriteOut <= inValid & memWriteIn;
                end
        end

        // Data fields hold their last values through a bubble.
        always_ff @(posedge Clock or negedge arstN)
        begin
                if (!arstN)
                begin
                        out          <= '0;
                        rtDataOut    <= '0;
                        pcOut        <= '0;
                        branchTarget <= '0;
                        rAddrOut     <= '0;
                        memFuncOut   <= '0;
                end
                else if (inValid)
                begin
                        out          <= result;
                        rtDataOut    <= storeData;
                        pcOut        <= pcIn;
                        branchTarget <= target;
                        rAddrOut     <= rAddrIn;
                        memFuncOut   <= memFuncIn;
                end
        end

endmodule

// File: source/exStage.sv
`timescale 1ns/1ps
`include "exStage_macros.svh"

module exStage (
        input  logic                      Clock,
        input  logic                      arstN,
        input  logic                      inValid,
        input  logic [`EX_DATA_W-1:0]     a,
        input  logic [`EX_DATA_W-1:0]     b,
        input  logic [`EX_DATA_W-1:0]     immediate,
        input  logic [`EX_DATA_W-1:0]     pcIn,
        input  logic [`EX_SHAMT_W-1:0]    shamt,
        input  exStagePkg::funcT          func,
        input  logic                      aluSrc,
        input  exStagePkg::branchCondT    branchCond,
        input  logic [`EX_REG_ADDR_W-1:0] rAddrIn,
        input  logic [`EX_MEMFUNC_W-1:0]  memFuncIn,
        input  logic                      regWriteIn,
        input  logic                      memReadIn,
        input  logic                      memToRegIn,
        input  logic                      memWriteIn,
        output logic                      outValid,
        output logic [`EX_DATA_W-1:0]     out,
        output logic [`EX_DATA_W-1:0]     rtDataOut,
        output logic [`EX_DATA_W-1:0]     pcOut,
        output logic [`EX_DATA_W-1:0]     branchTarget,
        output logic                      branchTaken,
        output logic [`EX_REG_ADDR_W-1:0] rAddrOut,
        output logic [`EX_MEMFUNC_W-1:0]  memFuncOut,
        output logic                      regWriteOut,
        output logic                      memReadOut,
        output logic                      memToRegOut,
        output logic                      memWriteOut
);

        logic [`EX_DATA_W-1:0] aluResult;
        logic [`EX_DATA_W-1:0] hiLoResult;
        logic                  hiLoRead;
        logic [`EX_DATA_W-1:0] result;
        logic                  taken;
        logic [`EX_DATA_W-1:0] target;

        aluCore i_aluCore (
                .a         (a),
                .b         (b),
                .immediate (immediate),
                .shamt     (shamt),
                .func      (func),
                .aluSrc    (aluSrc),
                .aluResult (aluResult)
        );

        hiLoUnit i_hiLoUnit (
                .Clock      (Clock),
                .arstN      (arstN),
                .inValid    (inValid),
                .a          (a),
                .b          (b),
                .func       (func),
                .hiLoResult (hiLoResult),
                .hiLoRead   (hiLoRead)
        );

        branchUnit i_branchUnit (
                .a          (a),
                .b          (b),
                .immediate  (immediate),
                .pcIn       (pcIn),
                .branchCond (branchCond),
                .taken      (taken),
                .target     (target)
        );

        assign result = hiLoRead ? hiLoResult : aluResult;  // mfhi and mflo bypass the ALU.

        exMemRegister i_exMemRegister (
                .Clock        (Clock),
                .arstN        (arstN),
                .inValid      (inValid),
                .taken        (taken),
                .regWriteIn   (regWriteIn),
                .memReadIn    (memReadIn),
                .memToRegIn   (memToRegIn),
                .memWriteIn   (memWriteIn),
                .result       (result),
                .storeData    (b),
                .pcIn         (pcIn),
                .target       (target),
                .rAddrIn      (rAddrIn),
                .memFuncIn    (memFuncIn),
                .outValid     (outValid),
                .out          (out),
                .rtDataOut    (rtDataOut),
                .pcOut        (pcOut),
                .branchTarget (branchTarget),
                .branchTaken  (branchTaken),
                .rAddrOut     (rAddrOut),
                .memFuncOut   (memFuncOut),
                .regWriteOut  (regWriteOut),
                .memReadOut   (memReadOut),
                .memToRegOut  (memToRegOut),
                .memWriteOut  (memWriteOut)
        );

endmodule

// File: source/exStagePkg.sv
`include "exStage_macros.svh"

package exStagePkg;

        // R-type function codes handled by the execute stage.
        typedef enum logic [`EX_FUNC_W-1:0] {
                funcSll   = 6'd0,
                funcSrl   = 6'd2,
                funcSra   = 6'd3,
                funcSllv  = 6'd4,
                funcSrlv  = 6'd6,
                funcMfhi  = 6'd16,
                funcMthi  = 6'd17,
                funcMflo  = 6'd18,
                funcMtlo  = 6'd19,
                funcMult  = 6'd24,
                funcMultu = 6'd25,
                funcAdd   = 6'd32,
                funcAddu  = 6'd33,
                funcSub   = 6'd34,
                funcSubu  = 6'd35,
                funcAnd   = 6'd36,
                funcOr    = 6'd37,
                funcXor   = 6'd38,
                funcNor   = 6'd39,
                funcSlt   = 6'd42,
                funcSltu  = 6'd43
        } funcT;

        // Branch and jump conditions from decode.
        typedef enum logic [1:0] {
                brNone = 2'd0,
                brEq   = 2'd1,
                brNe   = 2'd2,
                brJump = 2'd3
        } branchCondT;

endpackage

// File: source/exStage_macros.svh
`ifndef EX_STAGE_MACROS_SVH
`define EX_STAGE_MACROS_SVH

// Widths of the execute stage datapath, fixed at the MIPS values.

// Operands, immediate, PC and results.
`define EX_DATA_W 32

// Register file address of the destination register.
`define EX_REG_ADDR_W 5

// Shift amount field of R-type instructions.
`define EX_SHAMT_W 5

// Function code field of R-type instructions.
`define EX_FUNC_W 6

// Memory function code passed on to the memory stage.
`define EX_MEMFUNC_W 3

`endif

// File: source/hiLoUnit.sv
`timescale 1ns/1ps
`include "exStage_macros.svh"

module hiLoUnit (
        input  logic                  Clock,
        input  logic                  arstN,
        input  logic                  inValid,
        input  logic [`EX_DATA_W-1:0] a,
        input  logic [`EX_DATA_W-1:0] b,
        input  exStagePkg::funcT      func,
        output logic [`EX_DATA_W-1:0] hiLoResult,
        output logic                  hiLoRead
);

        logic [`EX_DATA_W-1:0]   hi;
        logic [`EX_DATA_W-1:0]   lo;
        logic [2*`EX_DATA_W-1:0] signedProd;
        logic [2*`EX_DATA_W-1:0] unsignedProd;

        assign signedProd   = $signed(a) * $signed(b);
        assign unsignedProd = a * b;

        always_ff @(posedge Clock or negedge arstN)
        begin
                if (!arstN)
                begin
                        hi <= '0;
                        lo <= '0;
                end
                else if (inValid)
                begin
                        case (func)
                                exStagePkg::funcMult:
                                begin
                                        hi <= signedProd[2*`EX_DATA_W-1:`EX_DATA_W];
                                        lo <= signedProd[`EX_DATA_W-1:0];
                                end
                                exStagePkg::funcMultu:
                                begin
                                        hi <= unsignedProd[2*`EX_DATA_W-1:`EX_DATA_W];
                                        lo <= unsignedProd[`EX_DATA_W-1:0];
                                end
                                exStagePkg::funcMthi:
                                begin
                                        hi <= a;
                                end
                                exStagePkg::funcMtlo:
                                begin
                                        lo <= a;
                                end
                                default:
                                begin
                                        hi <= hi;
                                        lo <= lo;
                                end
                        endcase
                end
        end

        // Read path is combinational, so a move right after a mult sees the new value.
        assign hiLoRead   = (func == exStagePkg::funcMfhi) || (func == exStagePkg::funcMflo);
        assign hiLoResult = (func == exStagePkg::funcMfhi) ? hi : lo;

endmodule

// File: verification/exStageTb.sv
`timescale 1ns/1ps
`include "exStage_macros.svh"

module exStageTb;

        localparam int testCycles   = 6 + 104 + 13 + 8 + 14;  // Reset, ALU, HI/LO, branch, fields.
        localparam int timeoutLimit = 2 * testCycles;

        logic                      Clock = 1'b0;
        logic                      arstN;
        logic                      inValid;
        logic [`EX_DATA_W-1:0]     a;
        logic [`EX_DATA_W-1:0]     b;
        logic [`EX_DATA_W-1:0]     immediate;
        logic [`EX_DATA_W-1:0]     pcIn;
        logic [`EX_SHAMT_W-1:0]    shamt;
        exStagePkg::funcT          func;
        logic                      aluSrc;
        exStagePkg::branchCondT    branchCond;
        logic [`EX_REG_ADDR_W-1:0] rAddrIn;
        logic [`EX_MEMFUNC_W-1:0]  memFuncIn;
        logic                      regWriteIn;
        logic                      memReadIn;
        logic                      memToRegIn;
        logic                      memWriteIn;
        logic                      outValid;
        logic [`EX_DATA_W-1:0]     out;
        logic [`EX_DATA_W-1:0]     rtDataOut;
        logic [`EX_DATA_W-1:0]     pcOut;
        logic [`EX_DATA_W-1:0]     branchTarget;
        logic                      branchTaken;
        logic [`EX_REG_ADDR_W-1:0] rAddrOut;
        logic [`EX_MEMFUNC_W-1:0]  memFuncOut;
        logic                      regWriteOut;
        logic                      memReadOut;
        logic                      memToRegOut;
        logic                      memWriteOut;

        logic [31:0] seed = 32'd79027;
        logic [31:0] shadowHi = '0;
        logic [31:0] shadowLo = '0;
        int          errors = 0;
        int          checks = 0;
        int          cycles = 0;

        exStage i_dut (
                .Clock        (Clock),
                .arstN        (arstN),
                .inValid      (inValid),
                .a            (a),
                .b            (b),
                .immediate    (immediate),
                .pcIn         (pcIn),
                .shamt        (shamt),
                .func         (func),
                .aluSrc       (aluSrc),
                .branchCond   (branchCond),
                .rAddrIn      (rAddrIn),
                .memFuncIn    (memFuncIn),
                .regWriteIn   (regWriteIn),
                .memReadIn    (memReadIn),
                .memToRegIn   (memToRegIn),
                .memWriteIn   (memWriteIn),
                .outValid     (outValid),
                .out          (out),
                .rtDataOut    (rtDataOut),
                .pcOut        (pcOut),
                .branchTarget (branchTarget),
                .branchTaken  (branchTaken),
                .rAddrOut     (rAddrOut),
                .memFuncOut   (memFuncOut),
                .regWriteOut  (regWriteOut),
                .memReadOut   (memReadOut),
                .memToRegOut  (memToRegOut),
                .memWriteOut  (memWriteOut)
        );

        always #50 Clock = ~Clock;

        function logic [31:0] nextRand();
                seed = seed * 32'd1664525 + 32'd1013904223;
                return seed;
        endfunction

        // Expected ALU result, written from the MIPS instruction definitions.
        function automatic logic [31:0] aluExpect(input exStagePkg::funcT f,
                                                  input logic [31:0] x,
                                                  input logic [31:0] y,
                                                  input logic [31:0] imm,
                                                  input logic [4:0] sh,
                                                  input logic src);
                logic [31:0] op2;
                logic [63:0] ext;
                logic [63:0] sraVal;
                op2    = src ? imm : y;
                ext    = {{32{op2[31]}}, op2};
                sraVal = ext >> sh;
                case (f)
                        exStagePkg::funcAdd, exStagePkg::funcAddu: return x + op2;
                        exStagePkg::funcSub, exStagePkg::funcSubu: return x + ~op2 + 32'd1;
                        exStagePkg::funcAnd:  return x & op2;
                        exStagePkg::funcOr:   return x | op2;
                        exStagePkg::funcXor:  return x ^ op2;
                        exStagePkg::funcNor:  return ~x & ~op2;
                        exStagePkg::funcSlt:  return (x[31] != op2[31]) ? {31'd0, x[31]}
                                                                        : {31'd0, x < op2};
                        exStagePkg::funcSltu: return {31'd0, x < op2};
                        exStagePkg::funcSll:  return op2 << sh;
                        exStagePkg::funcSrl:  return op2 >> sh;
                        exStagePkg::funcSra:  return sraVal[31:0];
                        exStagePkg::funcSllv: return op2 << x[4:0];
                        exStagePkg::funcSrlv: return op2 >> x[4:0];
                        default:              return 32'd0;
                endcase
        endfunction

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                checks++;
                assert (actual === expected)
                else
                begin
                        $display("** Error %s: expected 0x%h, actual 0x%h", name, expected, actual);
                        errors++;
                end
        endtask

        task automatic checkControlsLow();
                checkValue("outValid", 32'd0, {31'd0, outValid});
                checkValue("branchTaken", 32'd0, {31'd0, branchTaken});
                checkValue("regWriteOut", 32'd0, {31'd0, regWriteOut});
                checkValue("memReadOut", 32'd0, {31'd0, memReadOut});
                checkValue("memToRegOut", 32'd0, {31'd0, memToRegOut});
                checkValue("memWriteOut", 32'd0, {31'd0, memWriteOut});
        endtask

        task automatic randomizeInputs();
                a          = nextRand();
                b          = nextRand();
                immediate  = nextRand();
                pcIn       = nextRand() & 32'hFFFF_FFFC;
                shamt      = nextRand() >> 27;
                rAddrIn    = nextRand() >> 27;
                memFuncIn  = nextRand() >> 29;
                {regWriteIn, memReadIn, memToRegIn, memWriteIn} = nextRand() >> 28;
        endtask

        // Strobes the current inputs for one cycle and checks every output.
        task automatic strobeAndCheck();
                logic [31:0] expOut;
                logic        expTaken;
                logic [31:0] expTarget;
                logic [63:0] sProd;
                logic [63:0] uProd;
                logic [11:0] expFields;
                if (func == exStagePkg::funcMfhi)
                        expOut = shadowHi;
                else if (func == exStagePkg::funcMflo)
                        expOut = shadowLo;
                else
                        expOut = aluExpect(func, a, b, immediate, shamt, aluSrc);
                expTaken  = (branchCond == exStagePkg::brJump) ||
                            (branchCond == exStagePkg::brEq && a == b) ||
                            (branchCond == exStagePkg::brNe && a != b);
                expTarget = (branchCond == exStagePkg::brJump) ? immediate
                                                               : pcIn + {immediate[29:0], 2'b00};
                expFields = {rAddrIn, memFuncIn, regWriteIn, memReadIn, memToRegIn, memWriteIn};
                sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                uProd = {32'd0, a} * {32'd0, b};
                case (func)
                        exStagePkg::funcMult:  {shadowHi, shadowLo} = sProd;
                        exStagePkg::funcMultu: {shadowHi, shadowLo} = uProd;
                        exStagePkg::funcMthi:  shadowHi = a;
                        exStagePkg::funcMtlo:  shadowLo = a;
                        default:               ;
                endcase
                inValid = 1'b1;
                @(posedge Clock);
                #1;
                inValid = 1'b0;
                checkValue("outValid", 32'd1, {31'd0, outValid});
                checkValue("out", expOut, out);
                checkValue("rtDataOut", b, rtDataOut);
                checkValue("pcOut", pcIn, pcOut);
                checkValue("branchTaken", {31'd0, expTaken}, {31'd0, branchTaken});
                checkValue("branchTarget", expTarget, branchTarget);
                checkValue("rAddrOut", {27'd0, expFields[11:7]}, {27'd0, rAddrOut});
                checkValue("memFuncOut", {29'd0, expFields[6:4]}, {29'd0, memFuncOut});
                checkValue("controlsOut", {28'd0, expFields[3:0]},
                           {28'd0, regWriteOut, memReadOut, memToRegOut, memWriteOut});
        endtask

        // One cycle with no strobe. Controls drop and the data fields hold.
        task automatic idleCycle();
                logic [31:0] heldOut;
                logic [31:0] heldTarget;
                heldOut    = out;
                heldTarget = branchTarget;
                randomizeInputs();                     // Fresh data that must not be loaded.
                inValid    = 1'b0;
                @(posedge Clock);
                #1;
                checkControlsLow();
                checkValue("out", heldOut, out);
                checkValue("branchTarget", heldTarget, branchTarget);
        endtask

        task automatic resetTest();
                repeat (5)
                begin
                        @(posedge Clock);
                        #1;
                        checkControlsLow();
                        checkValue("out", 32'd0, out);
                end
                arstN = 1'b1;
                idleCycle();
        endtask

        task automatic aluTest();
                exStagePkg::funcT aluFuncs [13] = '{exStagePkg::funcAdd, exStagePkg::funcAddu,
                        exStagePkg::funcSub, exStagePkg::funcSubu, exStagePkg::funcAnd,
                        exStagePkg::funcOr, exStagePkg::funcXor, exStagePkg::funcNor,
                        exStagePkg::funcSlt, exStagePkg::funcSltu, exStagePkg::funcSll,
                        exStagePkg::funcSrl, exStagePkg::funcSra};
                for (int src = 0; src < 2; src++)
                        for (int f = 0; f < 13; f++)
                                for (int rep = 0; rep < 4; rep++)
                                begin
                                        randomizeInputs();
                                        aluSrc     = src[0];
                                        branchCond = exStagePkg::brNone;
                                        func       = aluFuncs[f];
                                        if (rep == 3 && f > 9)
                                                func = (f == 11) ? exStagePkg::funcSrlv
                                                                 : exStagePkg::funcSllv;
                                        strobeAndCheck();
                                end
        endtask

        task automatic runHiLo(input exStagePkg::funcT writeOp);
                func = writeOp;
                strobeAndCheck();
                func = exStagePkg::funcMfhi;
                strobeAndCheck();
                func = exStagePkg::funcMflo;
                strobeAndCheck();
        endtask

        task automatic hiLoTest();
                aluSrc = 1'b0;
                randomizeInputs();
                runHiLo(exStagePkg::funcMult);
                randomizeInputs();
                runHiLo(exStagePkg::funcMultu);
                a = 32'hFFFF_FFFD;                     // -3 times 7 gives -21.
                b = 32'd7;
                runHiLo(exStagePkg::funcMult);
                randomizeInputs();
                func = exStagePkg::funcMthi;
                strobeAndCheck();
                randomizeInputs();
                runHiLo(exStagePkg::funcMtlo);
        endtask

        task automatic branchTest();
                for (int c = 0; c < 4; c++)
                        for (int same = 0; same < 2; same++)
                        begin
                                randomizeInputs();
                                func       = exStagePkg::funcSubu;
                                branchCond = exStagePkg::branchCondT'(c);
                                b          = same ? a : ~a;
                                strobeAndCheck();
                        end
        endtask

        task automatic passThroughTest();
                repeat (6)
                begin
                        randomizeInputs();
                        func       = exStagePkg::funcAddu;
                        branchCond = exStagePkg::branchCondT'(nextRand() >> 30);
                        strobeAndCheck();
                        idleCycle();
                end
                randomizeInputs();
                func = exStagePkg::funcMult;           // Not strobed, so HI must not change.
                idleCycle();
                func = exStagePkg::funcMfhi;
                strobeAndCheck();
        endtask

        initial
        begin
                while (cycles < timeoutLimit)
                begin
                        @(posedge Clock);
                        cycles++;
                end
                $display("Timeout: the tests did not finish within %0d clock cycles", timeoutLimit);
                $display(">>> FAIL");
                $finish;
        end

        initial
        begin
                arstN      = 1'b0;
                inValid    = 1'b0;
                a          = '0;
                b          = '0;
                immediate  = '0;
                pcIn       = '0;
                shamt      = '0;
                func       = exStagePkg::funcSll;
                aluSrc     = 1'b0;
                branchCond = exStagePkg::brNone;
                rAddrIn    = '0;
                memFuncIn  = '0;
                regWriteIn = 1'b0;
                memReadIn  = 1'b0;
                memToRegIn = 1'b0;
                memWriteIn = 1'b0;
                resetTest();
                aluTest();
                hiLoTest();
                branchTest();
                passThroughTest();
                $display("Checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule
